// ==== hdl/wb_commit.sv ====
`include "wb_settings.svh"

module wb_commit (
    input  logic                      valid_in,
    input  wb_slot_pkg::wb_slots_t    slots,
    input  wb_slot_pkg::wb_rf_write_t reg_cand,
    input  wb_slot_pkg::wb_rf_write_t seg_cand,
    input  logic                      mem_cand,
    input  wb_slot_pkg::wb_store_t    store,
    input  wb_ctrl_pkg::wb_redirect_t redir_in,
    input  logic                      far_xfer,
    input  logic                      sq_full,
    output logic                      valid_out,
    output logic                      stall,
    output wb_slot_pkg::wb_rf_write_t reg_wr,
    output wb_slot_pkg::wb_rf_write_t seg_wr,
    output wb_slot_pkg::wb_slots_t    res,
    output logic                      mem_ld,
    output logic                      push,
    output wb_slot_pkg::wb_store_t    push_store,
    output wb_ctrl_pkg::wb_redirect_t redir_out
);

    assign stall     = valid_in & mem_cand & sq_full;
    assign valid_out = valid_in & ~stall;

    assign reg_wr.ld   = reg_cand.ld & {`WB_SLOTS{valid_out}};
    assign reg_wr.addr = reg_cand.addr;
    assign seg_wr.ld   = seg_cand.ld & {`WB_SLOTS{valid_out}};
    assign seg_wr.addr = seg_cand.addr;

    assign mem_ld = valid_out & mem_cand;
    assign push   = mem_ld;   // queue takes every committed store

    always_comb begin
        res = slots;
        if (far_xfer) begin
            // CS selector field of the far pointer
            res.slot[0].data = {{(`WB_DATA_W-16){1'b0}}, slots.slot[0].data[47:32]};
        end
    end

    always_comb begin
        push_store = store;
        if (far_xfer) begin
            push_store.size = 2'b11;
        end
    end

    always_comb begin
        redir_out         = redir_in;
        redir_out.resteer = redir_in.resteer & valid_out;
    end

endmodule

// ==== hdl/wb_ctrl_pkg.sv ====
package wb_ctrl_pkg;

    // p_op bits that mark a far transfer loading EIP and CS
    localparam int P_OP_FAR_A = 36;
    localparam int P_OP_FAR_B = 35;
    localparam int P_OP_FAR_C = 32;

    typedef struct packed {
        logic        valid;
        logic        taken;
        logic        correct;
        logic [31:0] fip;    // branch target
        logic [36:0] p_op;   // micro-op control word
    } wb_branch_t;

    typedef struct packed {
        logic [31:0] new_eip;
        logic [31:0] fip_even;
        logic [31:0] fip_odd;
        logic        resteer;
    } wb_redirect_t;

    typedef struct packed {
        logic       val;
        logic [3:0] ex_type;   // bit 3 is the interrupt flag
    } wb_except_t;

endpackage

// ==== hdl/wb_redirect.sv ====
module wb_redirect (
    input  wb_ctrl_pkg::wb_branch_t   branch,
    input  logic [31:0]               eip,
    input  logic [31:0]               slot0_data,
    input  logic                      ie,
    input  logic [3:0]                ie_type,
    input  logic                      interrupt,
    output wb_ctrl_pkg::wb_redirect_t redir,
    output logic                      far_xfer,
    output wb_ctrl_pkg::wb_except_t   except
);

    import wb_ctrl_pkg::*;

    logic [31:0] target;
    logic [31:0] line;
    logic [31:0] line_next;

    assign far_xfer = branch.p_op[P_OP_FAR_A] | branch.p_op[P_OP_FAR_B]
                    | branch.p_op[P_OP_FAR_C];

    // far jumps take EIP from the slot 0 result
    assign target        = far_xfer ? slot0_data : branch.fip;
    assign redir.new_eip = branch.taken ? target : eip;

    assign line      = {branch.fip[31:4], 4'h0};
    assign line_next = line + 32'd16;

    // bank select on bit 4 of the line
    assign redir.fip_even = line[4] ? line_next : line;
    assign redir.fip_odd  = line[4] ? line : line_next;

    assign redir.resteer = branch.valid & ~branch.correct;   // ungated

    assign except.val     = ie | interrupt;
    assign except.ex_type = {interrupt, ie_type[2:0]};

endmodule

// ==== hdl/wb_slot_pkg.sv ====
`include "wb_settings.svh"

package wb_slot_pkg;

    typedef struct packed {
        logic [`WB_DATA_W-1:0] data;
        logic [31:0]           dest;   // low 3 bits index reg/seg file
        logic                  is_reg;
        logic                  is_seg;
        logic                  is_mem;
        logic                  wb;     // write-back enable
    } wb_slot_t;

    typedef struct packed {
        wb_slot_t [`WB_SLOTS-1:0] slot;
        logic [1:0]               size;   // shared by all slots
    } wb_slots_t;

    typedef struct packed {
        logic [`WB_SLOTS-1:0]   ld;
        logic [3*`WB_SLOTS-1:0] addr;   // slot 0 in low bits
    } wb_rf_write_t;

    typedef struct packed {
        logic [31:0]           addr;
        logic [`WB_DATA_W-1:0] data;
        logic [1:0]            size;
    } wb_store_t;

endpackage

// ==== hdl/wb_slot_router.sv ====
`include "wb_settings.svh"

module wb_slot_router (
    input  wb_slot_pkg::wb_slots_t    slots,
    output wb_slot_pkg::wb_rf_write_t reg_cand,
    output wb_slot_pkg::wb_rf_write_t seg_cand,
    output logic                      mem_cand,
    output wb_slot_pkg::wb_store_t    store
);

    logic [`WB_SLOTS-1:0] mem_hit;

    genvar i;
    generate
        for (i = 0; i < `WB_SLOTS; i = i + 1) begin : g_slot
            assign reg_cand.ld[i] = slots.slot[i].is_reg & slots.slot[i].wb;
            assign seg_cand.ld[i] = slots.slot[i].is_seg & slots.slot[i].wb;
            assign mem_hit[i]     = slots.slot[i].is_mem & slots.slot[i].wb;

            // same index field feeds both files
            assign reg_cand.addr[3*i +: 3] = slots.slot[i].dest[2:0];
            assign seg_cand.addr[3*i +: 3] = slots.slot[i].dest[2:0];
        end
    endgenerate

    assign mem_cand = |mem_hit;

    // walk from the top so the lowest hit wins
    always_comb begin
        store      = '0;
        store.size = slots.size;
        for (int s = `WB_SLOTS - 1; s >= 0; s--) begin
            if (mem_hit[s]) begin
                store.addr = slots.slot[s].dest;
                store.data = slots.slot[s].data;
            end
        end
    end

endmodule

// ==== hdl/wb_store_queue.sv ====
`include "wb_settings.svh"

module wb_store_queue (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   push,
    input  wb_slot_pkg::wb_store_t push_store,
    input  logic                   mem_ready,
    output logic                   full,
    output logic                   mem_valid,
    output wb_slot_pkg::wb_store_t mem_store
);

    import wb_slot_pkg::*;

    localparam int DEPTH = `WB_SQ_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    wb_store_t        entries [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W:0]   count;
    logic             pop;

    assign pop       = mem_valid & mem_ready;
    assign mem_valid = (count != '0);
    assign full      = (count == (PTR_W + 1)'(DEPTH));
    assign mem_store = entries[rd_ptr];   // head

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;   // wraps, depth is a power of two
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= push_store;
        end
    end

endmodule

// ==== hdl/writeback_top.sv ====
module writeback_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      valid_in,
    input  wb_slot_pkg::wb_slots_t    slots,
    input  logic [31:0]               eip,
    input  wb_ctrl_pkg::wb_branch_t   branch,
    input  logic [15:0]               cs,
    input  logic [17:0]               eflags,
    input  logic                      ie,
    input  logic [3:0]                ie_type,
    input  logic                      interrupt,
    input  logic                      mem_ready,
    output logic                      valid_out,
    output logic                      stall,
    output wb_slot_pkg::wb_slots_t    res,
    output wb_slot_pkg::wb_rf_write_t reg_wr,
    output wb_slot_pkg::wb_rf_write_t seg_wr,
    output logic                      mem_ld,
    output wb_ctrl_pkg::wb_redirect_t redir,
    output logic [15:0]               cs_out,
    output logic [17:0]               eflags_out,
    output wb_ctrl_pkg::wb_except_t   except,
    output logic                      mem_valid,
    output wb_slot_pkg::wb_store_t    mem_store
);

    import wb_slot_pkg::*;
    import wb_ctrl_pkg::*;

    wb_rf_write_t reg_cand;
    wb_rf_write_t seg_cand;
    logic         mem_cand;
    wb_store_t    store;
    wb_redirect_t redir_raw;   // resteer not yet gated
    logic         far_xfer;
    logic         sq_full;
    logic         push;
    wb_store_t    push_store;

    assign cs_out     = cs;
    assign eflags_out = eflags;

    wb_slot_router u_router (
        .slots    (slots),
        .reg_cand (reg_cand),
        .seg_cand (seg_cand),
        .mem_cand (mem_cand),
        .store    (store)
    );

    wb_redirect u_redirect (
        .branch     (branch),
        .eip        (eip),
        .slot0_data (slots.slot[0].data[31:0]),
        .ie         (ie),
        .ie_type    (ie_type),
        .interrupt  (interrupt),
        .redir      (redir_raw),
        .far_xfer   (far_xfer),
        .except     (except)
    );

    wb_commit u_commit (
        .valid_in   (valid_in),
        .slots      (slots),
        .reg_cand   (reg_cand),
        .seg_cand   (seg_cand),
        .mem_cand   (mem_cand),
        .store      (store),
        .redir_in   (redir_raw),
        .far_xfer   (far_xfer),
        .sq_full    (sq_full),
        .valid_out  (valid_out),
        .stall      (stall),
        .reg_wr     (reg_wr),
        .seg_wr     (seg_wr),
        .res        (res),
        .mem_ld     (mem_ld),
        .push       (push),
        .push_store (push_store),
        .redir_out  (redir)
    );

    wb_store_queue u_store_queue (
        .clk        (clk),
        .reset      (reset),
        .push       (push),
        .push_store (push_store),
        .mem_ready  (mem_ready),
        .full       (sq_full),
        .mem_valid  (mem_valid),
        .mem_store  (mem_store)
    );

endmodule

// ==== include/wb_settings.svh ====
`ifndef WB_SETTINGS_SVH
`define WB_SETTINGS_SVH

// result slots per retiring instruction
`define WB_SLOTS 4

`define WB_DATA_W 64

// power of two
`define WB_SQ_DEPTH 4

`endif

// ==== project.f ====
+incdir+include
hdl/wb_slot_pkg.sv
hdl/wb_ctrl_pkg.sv
hdl/wb_slot_router.sv
hdl/wb_redirect.sv
hdl/wb_commit.sv
hdl/wb_store_queue.sv
hdl/writeback_top.sv
tb/tb_writeback.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the writeback testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module tb_writeback \
    -f project.f \
    -o tb_writeback_sim

./obj_dir/tb_writeback_sim > sim.log 2>&1
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "simulation reported failure, see sim.log"
    exit 1
fi

echo "simulation finished, see sim.log"

// ==== tb/tb_writeback.sv ====
`include "wb_settings.svh"

module tb_writeback;

    import wb_slot_pkg::*;
    import wb_ctrl_pkg::*;

    typedef struct packed {
        logic         valid_out;
        logic         stall;
        wb_rf_write_t reg_wr;
        wb_rf_write_t seg_wr;
        wb_slots_t    res;
        logic         mem_ld;
        wb_store_t    store;
        wb_redirect_t redir;
        wb_except_t   except;
    } expect_t;

    logic clk, reset, valid_in, ie, interrupt, mem_ready;
    wb_slots_t    slots;
    logic [31:0]  eip;
    wb_branch_t   branch;
    logic [15:0]  cs, cs_out;
    logic [17:0]  eflags, eflags_out;
    logic [3:0]   ie_type;
    logic         valid_out, stall, mem_ld, mem_valid;
    wb_slots_t    res;
    wb_rf_write_t reg_wr, seg_wr;
    wb_redirect_t redir;
    wb_except_t   except;
    wb_store_t    mem_store;

    wb_store_t   exp_q[$];   // stores committed but not yet drained
    logic [31:0] lfsr_state = 32'd72099;
    int          errors = 0;
    int          checks = 0;
    int          pops = 0;
    int          ready_mode = 0;   // 0 low, 1 high, 2 random
    int          waits;
    logic        hold = 1'b0;      // instruction stalled at the last edge
    logic        stall_seen = 1'b0;

    writeback_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'hD000_0001 : 32'h0);
    endfunction

    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v[k] = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic expect_t wb_expect(input logic v_in, input wb_slots_t s,
            input logic [31:0] pc, input wb_branch_t br, input logic ie_i,
            input logic [3:0] iet, input logic intr, input logic q_full);
        expect_t     e;
        logic        far;
        logic        found;
        e = '0;
        far = br.p_op[36] | br.p_op[35] | br.p_op[32];
        found = 1'b0;
        e.store.size = far ? 2'b11 : s.size;
        for (int k = 0; k < `WB_SLOTS; k++) begin
            e.reg_wr.ld[k] = s.slot[k].wb & s.slot[k].is_reg;
            e.seg_wr.ld[k] = s.slot[k].wb & s.slot[k].is_seg;
            e.reg_wr.addr[3*k +: 3] = s.slot[k].dest[2:0];
            e.seg_wr.addr[3*k +: 3] = s.slot[k].dest[2:0];
            if (s.slot[k].wb && s.slot[k].is_mem && !found) begin   // first memory slot
                found = 1'b1;
                e.store.addr = s.slot[k].dest;
                e.store.data = s.slot[k].data;
            end
        end
        e.stall = v_in & found & q_full;
        e.valid_out = v_in & ~e.stall;
        e.reg_wr.ld = e.valid_out ? e.reg_wr.ld : '0;
        e.seg_wr.ld = e.valid_out ? e.seg_wr.ld : '0;
        e.mem_ld = e.valid_out & found;
        e.res = s;
        if (far) e.res.slot[0].data = 64'(s.slot[0].data[47:32]);   // cs selector
        if (!br.taken) e.redir.new_eip = pc;
        else e.redir.new_eip = far ? s.slot[0].data[31:0] : br.fip;
        // even line rounds up to the next 32-byte boundary when bit 4 is set
        e.redir.fip_even = {br.fip[31:5] + 27'(br.fip[4]), 5'b0_0000};
        e.redir.fip_odd = {br.fip[31:5], 5'b1_0000};   // odd line always has bit 4 set
        e.redir.resteer = br.valid & ~br.correct & e.valid_out;
        e.except.val = ie_i | intr;
        e.except.ex_type = {intr, iet[2:0]};
        return e;
    endfunction

    task automatic check_field(input string name, input logic [511:0] exp_v,
            input logic [511:0] act_v);
        checks++;
        if (exp_v !== act_v) begin
            errors++;
            $display("ERROR %s expected %0h actual %0h", name, exp_v, act_v);
        end
    endtask

    task automatic abort_run(input string why);
        $display("timeout: %s", why);
        $display("checks %0d, errors %0d, stores drained %0d", checks, errors, pops);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    task automatic step_cycle(input int mode);   // 0 idle, 1 random, 2 store
        @(negedge clk);
        case (ready_mode)
            0: mem_ready = 1'b0;
            1: mem_ready = 1'b1;
            default: mem_ready = take_bits(1) != 0;
        endcase
        if (!hold) begin
            valid_in = (mode == 2) ? 1'b1 : (mode == 1 && take_bits(2) != 0);
            if (mode != 0) begin
                for (int k = 0; k < `WB_SLOTS; k++) begin
                    slots.slot[k].data   = take_bits(64);
                    slots.slot[k].dest   = 32'(take_bits(32));
                    slots.slot[k].is_reg = take_bits(1) != 0;
                    slots.slot[k].is_seg = take_bits(1) != 0;
                    slots.slot[k].is_mem = take_bits(1) != 0;
                    slots.slot[k].wb     = take_bits(1) != 0;
                end
                slots.size = 2'(take_bits(2));
                eip = 32'(take_bits(32));
                branch.valid = take_bits(1) != 0;
                branch.taken = take_bits(1) != 0;
                branch.correct = take_bits(1) != 0;
                branch.fip = 32'(take_bits(32));
                branch.p_op = 37'(take_bits(37));
                if (take_bits(2) != 0) begin   // far transfer one time in four
                    branch.p_op[36] = 1'b0;
                    branch.p_op[35] = 1'b0;
                    branch.p_op[32] = 1'b0;
                end
                cs = 16'(take_bits(16));
                eflags = 18'(take_bits(18));
                ie = take_bits(1) != 0;
                ie_type = 4'(take_bits(4));
                interrupt = take_bits(1) != 0;
                if (mode == 2) begin
                    slots.slot[1].is_mem = 1'b1;
                    slots.slot[1].wb = 1'b1;
                end
            end
        end
    endtask

    always @(posedge clk) begin : compare_blk
        expect_t e;
        if (!reset) begin
            e = wb_expect(valid_in, slots, eip, branch, ie, ie_type, interrupt,
                exp_q.size() == `WB_SQ_DEPTH);
            check_field("valid_out", 512'(e.valid_out), 512'(valid_out));
            check_field("stall", 512'(e.stall), 512'(stall));
            check_field("reg_wr", 512'(e.reg_wr), 512'(reg_wr));
            check_field("seg_wr", 512'(e.seg_wr), 512'(seg_wr));
            check_field("result", 512'(e.res), 512'(res));
            check_field("mem_ld", 512'(e.mem_ld), 512'(mem_ld));
            check_field("redirect", 512'(e.redir), 512'(redir));
            check_field("exception", 512'(e.except), 512'(except));
            check_field("cs_pass", 512'(cs), 512'(cs_out));
            check_field("eflags_pass", 512'(eflags), 512'(eflags_out));
            check_field("mem_valid", 512'(exp_q.size() != 0), 512'(mem_valid));
            if (exp_q.size() != 0 && mem_ready) begin
                check_field("store_order", 512'(exp_q[0]), 512'(mem_store));
                void'(exp_q.pop_front());
                pops++;
            end
            if (e.mem_ld) exp_q.push_back(e.store);
            if (e.stall && stall) stall_seen = 1'b1;
            hold = e.stall;
        end
    end

    initial begin
        reset = 1'b1;
        valid_in = 1'b0;
        slots = '0;
        eip = '0;
        branch = '0;
        cs = '0;
        eflags = '0;
        ie = 1'b0;
        ie_type = '0;
        interrupt = 1'b0;
        mem_ready = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        ready_mode = 2;
        repeat (400) step_cycle(1);

        ready_mode = 0;   // memory blocked, queue fills
        stall_seen = 1'b0;
        waits = 0;
        while (!stall_seen) begin
            step_cycle(2);
            waits++;
            if (waits > 40) abort_run("stall never rose with the store queue full");
        end
        repeat (3) step_cycle(2);
        ready_mode = 1;
        waits = 0;
        while (hold) begin
            step_cycle(2);
            waits++;
            if (waits > 20) abort_run("stalled store never committed after memory freed");
        end

        waits = 0;
        while (exp_q.size() != 0 || mem_valid) begin
            step_cycle(0);
            waits++;
            if (waits > 40) abort_run("store queue did not drain");
        end
        repeat (2) step_cycle(0);

        $display("checks %0d, errors %0d, stores drained %0d", checks, errors, pops);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
